// File: build.f
design/fir_pkg.sv
design/fir_control.sv
design/fir_coeff_store.sv
design/fir_delay_line.sv
design/fir_multiply.sv
design/fir_accumulate.sv
design/fir_top.sv
tb/fir_checker.sv
tb/tb_fir.sv

// File: design/fir_accumulate.sv
// Adder tree and output register; exact result with no rounding, data_out holds between results
`timescale 1ns/100ps

module fir_accumulate #(
	parameter int LENGTH     = 10,
	parameter int DATA_WIDTH = 8
) (
	input  logic                           clock,
	input  logic                           rst_n,
	input  logic [LENGTH*2*DATA_WIDTH-1:0] products,
	input  logic                           products_valid,
	output logic signed [fir_pkg::result_width(DATA_WIDTH, LENGTH)-1:0] data_out,
	output logic                           out_valid
);

	localparam int PROD_WIDTH   = fir_pkg::result_width(DATA_WIDTH, 1);
	localparam int RESULT_WIDTH = fir_pkg::result_width(DATA_WIDTH, LENGTH);
	localparam int NODES        = 2 * LENGTH - 1;

	// The tree is stored heap style
	// Node i adds nodes 2i+1 and 2i+2, so nodes 0 to LENGTH-2 are adders
	// Nodes LENGTH-1 upward are the leaves, one per product
	// This shape works for any LENGTH, odd counts just give an uneven last level
	logic signed [RESULT_WIDTH-1:0] node [NODES];

	for (genvar j = 0; j < LENGTH; j++) begin : g_leaf
		logic signed [PROD_WIDTH-1:0] prod_s;

		assign prod_s = products[j*PROD_WIDTH +: PROD_WIDTH];
		// Signed to wider signed, so this is a sign extension
		assign node[LENGTH-1+j] = prod_s;
	end

	for (genvar i = 0; i < LENGTH - 1; i++) begin : g_add
		assign node[i] = node[2*i+1] + node[2*i+2];
	end

	// Node 0 carries the full sum of all taps
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			data_out  <= '0;
			out_valid <= 1'b0;
		end else begin
			out_valid <= products_valid;
			if (products_valid)
				data_out <= node[0];
		end
	end

endmodule

// File: design/fir_coeff_store.sv
// Coefficient shift register; contents are only replaced by a full load, with no reload path
`timescale 1ns/100ps

module fir_coeff_store #(
	parameter int LENGTH     = 10,
	parameter int DATA_WIDTH = 8
) (
	input  logic                         clock,
	input  logic                         rst_n,
	input  logic                         coeff_shift,
	input  logic signed [DATA_WIDTH-1:0] coefficient_in,
	output logic [LENGTH*DATA_WIDTH-1:0] coeffs
);

	logic signed [DATA_WIDTH-1:0] slot [LENGTH];

	// New values enter at slot 0 and move up one slot per shift
	// After LENGTH shifts the first coefficient loaded sits in the last slot
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			for (int n = 0; n < LENGTH; n++)
				slot[n] <= '0;
		end else if (coeff_shift) begin
			slot[0] <= coefficient_in;
			for (int n = 1; n < LENGTH; n++)
				slot[n] <= slot[n-1];
		end
	end

	// Reverse the slots so that field k of coeffs is h[k] in load order
	for (genvar k = 0; k < LENGTH; k++) begin : g_order
		assign coeffs[k*DATA_WIDTH +: DATA_WIDTH] = slot[LENGTH-1-k];
	end

endmodule

// File: design/fir_control.sv
// FIR sequencer; coefficient_in must be valid for LENGTH cycles after load starts, stop is final
`timescale 1ns/100ps

module fir_control #(
	parameter int LENGTH = 10
) (
	input  logic               clock,
	input  logic               rst_n,
	input  logic               load_coefficients,
	input  logic               load_data,
	input  logic               stop_data_load,
	output fir_pkg::fir_state_e state,
	output logic               coeff_shift,
	output logic               sample_shift
);

	// A single tap still needs a one bit counter to keep the declaration legal
	localparam int COUNT_WIDTH = (LENGTH > 1) ? $clog2(LENGTH) : 1;
	localparam logic [COUNT_WIDTH-1:0] LAST_COEFF = COUNT_WIDTH'(LENGTH - 1);

	fir_pkg::fir_state_e     state_next;
	logic [COUNT_WIDTH-1:0] coeff_count;

	// Every cycle in the load state shifts one coefficient in
	assign coeff_shift = (state == fir_pkg::st_load_coefficients);

	// Downstream stages never look at the state, so strobes are qualified here
	// A strobe in the same cycle as stop is still accepted
	assign sample_shift = load_data && (state == fir_pkg::st_filtering);

	always_comb begin
		state_next = state;
		unique case (state)
			fir_pkg::st_idle: begin
				// The load request is a level and is only looked at here
				if (load_coefficients)
					state_next = fir_pkg::st_load_coefficients;
			end
			fir_pkg::st_load_coefficients: begin
				// The edge that takes the last coefficient also enters filtering
				if (coeff_count == LAST_COEFF)
					state_next = fir_pkg::st_filtering;
			end
			fir_pkg::st_filtering: begin
				if (stop_data_load)
					state_next = fir_pkg::st_stopped;
			end
			default: begin
				// Stopped holds until reset
				state_next = fir_pkg::st_stopped;
			end
		endcase
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			state <= fir_pkg::st_idle;
		end else begin
			state <= state_next;
		end
	end

	// Counts the coefficients taken so far in the current load
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			coeff_count <= '0;
		end else if (state == fir_pkg::st_idle) begin
			coeff_count <= '0;
		end else if (coeff_shift) begin
			coeff_count <= coeff_count + 1'b1;
		end
	end

endmodule

// File: design/fir_delay_line.sv
// Sample delay line; shifts only on accepted strobes, history before the first one reads zero
`timescale 1ns/100ps

module fir_delay_line #(
	parameter int LENGTH     = 10,
	parameter int DATA_WIDTH = 8
) (
	input  logic                         clock,
	input  logic                         rst_n,
	input  logic                         sample_shift,
	input  logic signed [DATA_WIDTH-1:0] data_in,
	output logic [LENGTH*DATA_WIDTH-1:0] taps,
	output logic                         taps_valid
);

	logic signed [DATA_WIDTH-1:0] slot [LENGTH];

	// Slot 0 takes the newest sample and slot k holds x[t-k]
	// The zero reset gives the filter an all-zero history
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			for (int n = 0; n < LENGTH; n++)
				slot[n] <= '0;
			taps_valid <= 1'b0;
		end else begin
			// One cycle marker telling the multiply stage the taps just moved
			taps_valid <= sample_shift;
			if (sample_shift) begin
				slot[0] <= data_in;
				for (int n = 1; n < LENGTH; n++)
					slot[n] <= slot[n-1];
			end
		end
	end

	for (genvar k = 0; k < LENGTH; k++) begin : g_flat
		assign taps[k*DATA_WIDTH +: DATA_WIDTH] = slot[k];
	end

endmodule

// File: design/fir_multiply.sv
// Registered multiply stage, one signed product per tap; products are only meaningful when valid
`timescale 1ns/100ps

module fir_multiply #(
	parameter int LENGTH     = 10,
	parameter int DATA_WIDTH = 8
) (
	input  logic                           clock,
	input  logic                           rst_n,
	input  logic [LENGTH*DATA_WIDTH-1:0]   taps,
	input  logic                           taps_valid,
	input  logic [LENGTH*DATA_WIDTH-1:0]   coeffs,
	output logic [LENGTH*2*DATA_WIDTH-1:0] products,
	output logic                           products_valid
);

	// A single product has no growth bits, so this is twice DATA_WIDTH
	localparam int PROD_WIDTH = fir_pkg::result_width(DATA_WIDTH, 1);

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			products_valid <= 1'b0;
		end else begin
			products_valid <= taps_valid;
		end
	end

	for (genvar k = 0; k < LENGTH; k++) begin : g_tap
		logic signed [DATA_WIDTH-1:0] tap_s;
		logic signed [DATA_WIDTH-1:0] coeff_s;
		logic signed [PROD_WIDTH-1:0] prod_s;

		assign tap_s   = taps[k*DATA_WIDTH +: DATA_WIDTH];
		assign coeff_s = coeffs[k*DATA_WIDTH +: DATA_WIDTH];

		// Both operands are signed, so they are sign-extended to the product width
		// The register only loads on fresh taps to keep the multipliers quiet
		always_ff @(posedge clock) begin
			if (taps_valid)
				prod_s <= tap_s * coeff_s;
		end

		assign products[k*PROD_WIDTH +: PROD_WIDTH] = prod_s;
	end

endmodule

// File: design/fir_pkg.sv
// Shared FIR definitions; the width rule assumes both operands are signed and DATA_WIDTH wide
package fir_pkg;

	// Control sequence of the filter
	// The encoding is visible on the top-level state port, so keep it stable
	// Stopped is a terminal state and only reset leaves it
	typedef enum logic [1:0] {
		st_idle              = 2'd0,
		st_load_coefficients = 2'd1,
		st_filtering         = 2'd2,
		st_stopped           = 2'd3
	} fir_state_e;

	// Exact width of a sum of length products of two data_width signed values
	// One product needs twice the operand width, since -2^(w-1) squared is positive
	// Every doubling of the number of terms needs one more bit of growth
	// Called with length 1 it gives the width of a single product
	function automatic int result_width(input int data_width, input int length);
		int growth;
		growth = $clog2(length);
		return 2 * data_width + growth;
	endfunction

endpackage

// File: design/fir_top.sv
// Streaming FIR top; three cycle latency from an accepted strobe, no back-pressure on the output
`timescale 1ns/100ps

module fir_top #(
	parameter int LENGTH     = 10,
	parameter int DATA_WIDTH = 8
) (
	input  logic                         clock,
	input  logic                         rst_n,
	input  logic                         load_coefficients,
	input  logic signed [DATA_WIDTH-1:0] coefficient_in,
	input  logic                         load_data,
	input  logic signed [DATA_WIDTH-1:0] data_in,
	input  logic                         stop_data_load,
	output logic signed [fir_pkg::result_width(DATA_WIDTH, LENGTH)-1:0] data_out,
	output logic                         out_valid,
	output fir_pkg::fir_state_e          state
);

	logic                           coeff_shift;
	logic                           sample_shift;
	logic [LENGTH*DATA_WIDTH-1:0]   coeffs;
	logic [LENGTH*DATA_WIDTH-1:0]   taps;
	logic                           taps_valid;
	logic [LENGTH*2*DATA_WIDTH-1:0] products;
	logic                           products_valid;

	// Sequencing and strobe qualification
	fir_control #(
		.LENGTH (LENGTH)
	) i_fir_control (
		.clock             (clock),
		.rst_n             (rst_n),
		.load_coefficients (load_coefficients),
		.load_data         (load_data),
		.stop_data_load    (stop_data_load),
		.state             (state),
		.coeff_shift       (coeff_shift),
		.sample_shift      (sample_shift)
	);

	fir_coeff_store #(
		.LENGTH     (LENGTH),
		.DATA_WIDTH (DATA_WIDTH)
	) i_fir_coeff_store (
		.clock          (clock),
		.rst_n          (rst_n),
		.coeff_shift    (coeff_shift),
		.coefficient_in (coefficient_in),
		.coeffs         (coeffs)
	);

	// First pipeline edge, the sample is captured here
	fir_delay_line #(
		.LENGTH     (LENGTH),
		.DATA_WIDTH (DATA_WIDTH)
	) i_fir_delay_line (
		.clock        (clock),
		.rst_n        (rst_n),
		.sample_shift (sample_shift),
		.data_in      (data_in),
		.taps         (taps),
		.taps_valid   (taps_valid)
	);

	// Second edge registers the products
	fir_multiply #(
		.LENGTH     (LENGTH),
		.DATA_WIDTH (DATA_WIDTH)
	) i_fir_multiply (
		.clock          (clock),
		.rst_n          (rst_n),
		.taps           (taps),
		.taps_valid     (taps_valid),
		.coeffs         (coeffs),
		.products       (products),
		.products_valid (products_valid)
	);

	// Third edge registers the sum onto data_out
	fir_accumulate #(
		.LENGTH     (LENGTH),
		.DATA_WIDTH (DATA_WIDTH)
	) i_fir_accumulate (
		.clock          (clock),
		.rst_n          (rst_n),
		.products       (products),
		.products_valid (products_valid),
		.data_out       (data_out),
		.out_valid      (out_valid)
	);

endmodule

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_fir -f build.f -o tb_fir_sim
./obj_dir/tb_fir_sim | tee sim.log

if grep -q "Something failed" sim.log; then
	echo "Simulation reported a failure"
	exit 1
fi
if ! grep -q "Everything OK" sim.log; then
	echo "Simulation ended without a verdict"
	exit 1
fi
echo "Simulation passed"

// File: tb/fir_checker.sv
// FIR result checker; results must come back in strobe order and are sampled on the falling edge
`timescale 1ns/100ps

module fir_checker #(
	parameter int RESULT_WIDTH = 20,
	parameter int LATENCY      = 3
) (
	input  logic                           clock,
	input  logic                           rst_n,
	input  logic signed [RESULT_WIDTH-1:0] data_out,
	input  logic                           out_valid,
	input  fir_pkg::fir_state_e            state,
	input  logic                           expect_push,
	input  logic signed [RESULT_WIDTH-1:0] expect_value,
	input  logic                           state_check,
	input  fir_pkg::fir_state_e            state_expect,
	input  logic                           end_check,
	input  logic                           back_to_back,
	input  logic [8*24-1:0]                test_name,
	output int                             error_count
);

	// Expected results in strobe order, oldest first
	logic signed [RESULT_WIDTH-1:0] expected_q [$];
	logic signed [RESULT_WIDTH-1:0] expected;
	// Most results owed at one time since the group started
	int                             peak = 0;

	// The falling edge is half a cycle away from both the DUT registers and the driver
	always @(negedge clock) begin
		if (rst_n) begin
			// A strobe and its own result are never in the same cycle, so push first
			if (expect_push)
				expected_q.push_back(expect_value);

			if (out_valid) begin
				if (expected_q.size() == 0) begin
					// A result with nothing owed means a strobe leaked through the gating
					$display("Result %0d appeared in test %0s with no accepted sample behind it",
						data_out, test_name);
					error_count++;
				end else begin
					expected = expected_q.pop_front();
					if (data_out !== expected) begin
						$display("FAIL %0s expected %0d actual %0d", test_name, expected, data_out);
						error_count++;
					end
				end
			end

			// With strobes back to back the owed count settles at the pipeline latency
			if (expected_q.size() > peak)
				peak = expected_q.size();

			if (state_check && state !== state_expect) begin
				$display("FAIL %0s state expected %s actual %s",
					test_name, state_expect.name(), state.name());
				error_count++;
			end

			// Anything left here was accepted but never came out
			if (end_check && expected_q.size() != 0) begin
				$display("%0d expected results never arrived in test %0s",
					expected_q.size(), test_name);
				error_count++;
			end
			if (end_check && back_to_back && peak != LATENCY) begin
				$display("FAIL %0s in flight expected %0d actual %0d", test_name, LATENCY, peak);
				error_count++;
			end
			if (end_check)
				peak = 0;
		end
	end

endmodule

// File: tb/fir_patterns.txt
# kind value expected: coeff and stray give a value only, test gives a name and 1 for random gaps
# sample and stop push an expected result, stop also raises stop_data_load in the same cycle
test impulse 1
stray 5
stray -7
coeff 3
coeff -1
coeff 4
coeff 1
coeff -5
coeff 9
coeff 2
coeff -6
coeff 5
coeff -3
sample 1 3
sample 0 -1
sample 0 4
sample 0 1
sample 0 -5
sample 0 9
sample 0 2
sample 0 -6
sample 0 5
sample 0 -3
test full_scale 0
coeff -128
coeff -128
coeff -128
coeff -128
coeff -128
coeff -128
coeff -128
coeff -128
coeff -128
coeff -128
sample -128 16384
sample -128 32768
sample -128 49152
sample -128 65536
sample -128 81920
sample -128 98304
sample -128 114688
sample -128 131072
sample -128 147456
sample -128 163840
sample 127 131200
sample -1 114944
sample 5 97920
test gaps_and_stop 1
coeff -128
coeff -128
coeff -128
coeff -128
coeff -128
coeff -128
coeff -128
coeff -128
coeff -128
coeff -128
sample -128 16384
sample -128 32768
sample -128 49152
sample -128 65536
sample -128 81920
sample -128 98304
sample -128 114688
sample -128 131072
sample -128 147456
sample -128 163840
sample 127 131200
sample -1 114944
sample 5 97920
stop 7 80640
stray 9

// File: tb/tb_fir.sv
// FIR testbench; run from the project root, the pattern groups assume LENGTH 10 and DATA_WIDTH 8
`timescale 1ns/100ps

module tb_fir;

	localparam int    LENGTH       = 10;
	localparam int    DATA_WIDTH   = 8;
	localparam int    RESULT_WIDTH = fir_pkg::result_width(DATA_WIDTH, LENGTH);
	localparam int    LATENCY      = 3;
	localparam string PATTERN_FILE = "tb/fir_patterns.txt";

	logic                           clock;
	logic                           rst_n;
	logic                           load_coefficients;
	logic signed [DATA_WIDTH-1:0]   coefficient_in;
	logic                           load_data;
	logic signed [DATA_WIDTH-1:0]   data_in;
	logic                           stop_data_load;
	logic signed [RESULT_WIDTH-1:0] data_out;
	logic                           out_valid;
	fir_pkg::fir_state_e            state;

	// Driver to checker side channel
	logic                           expect_push;
	logic signed [RESULT_WIDTH-1:0] expect_value;
	logic                           state_check;
	fir_pkg::fir_state_e            state_expect;
	logic                           end_check;
	logic [8*24-1:0]                test_name;
	int                             checker_errors;

	int          fd;
	int          fields;
	int          value;
	int          result;
	string       line;
	logic [63:0] kind;
	int          file_errors = 0;
	int          line_count  = 0;
	int          coeff_index = 0;
	logic [31:0] lfsr        = 32'hec249c5d;
	bit          counted     = 1'b0;
	bit          started     = 1'b0;
	bit          gapped      = 1'b0;

	fir_top #(
		.LENGTH     (LENGTH),
		.DATA_WIDTH (DATA_WIDTH)
	) i_fir_top (
		.clock             (clock),
		.rst_n             (rst_n),
		.load_coefficients (load_coefficients),
		.coefficient_in    (coefficient_in),
		.load_data         (load_data),
		.data_in           (data_in),
		.stop_data_load    (stop_data_load),
		.data_out          (data_out),
		.out_valid         (out_valid),
		.state             (state)
	);

	fir_checker #(
		.RESULT_WIDTH (RESULT_WIDTH),
		.LATENCY      (LATENCY)
	) i_fir_checker (
		.clock        (clock),
		.rst_n        (rst_n),
		.data_out     (data_out),
		.out_valid    (out_valid),
		.state        (state),
		.expect_push  (expect_push),
		.expect_value (expect_value),
		.state_check  (state_check),
		.state_expect (state_expect),
		.end_check    (end_check),
		.back_to_back (!gapped),
		.test_name    (test_name),
		.error_count  (checker_errors)
	);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	// One step of a 32 bit Galois LFSR, the bit shifted out is the random bit
	function automatic bit next_random_bit();
		bit out;
		out  = lfsr[0];
		lfsr = lfsr >> 1;
		if (out)
			lfsr = lfsr ^ 32'h80200003;
		return out;
	endfunction

	// Inputs change a short fixed time after the rising edge
	task automatic next_cycle();
		@(posedge clock);
		#2;
	endtask

	// The checker compares the state on the falling edge of this cycle
	task automatic expect_state(input fir_pkg::fir_state_e want);
		state_expect = want;
		state_check  = 1'b1;
		next_cycle();
		state_check  = 1'b0;
	endtask

	task automatic apply_reset();
		rst_n       = 1'b0;
		coeff_index = 0;
		repeat (4) next_cycle();
		rst_n = 1'b1;
		// Idle is the first state out of reset
		expect_state(fir_pkg::st_idle);
	endtask

	// The first coefficient also raises the load request one cycle ahead
	task automatic load_coefficient(input int coefficient);
		if (coeff_index == 0) begin
			load_coefficients = 1'b1;
			next_cycle();
			load_coefficients = 1'b0;
		end
		coefficient_in = DATA_WIDTH'(coefficient);
		// A strobe while loading must be dropped and leave the history at zero
		load_data = 1'b1;
		data_in   = DATA_WIDTH'(coefficient);
		next_cycle();
		load_data = 1'b0;
		coeff_index++;
		if (coeff_index == LENGTH)
			expect_state(fir_pkg::st_filtering);
	endtask

	// One load_data strobe, with the result it owes when the DUT should accept it
	task automatic strobe(input int sample, input bit owed, input int want, input bit stop);
		load_data      = 1'b1;
		data_in        = DATA_WIDTH'(sample);
		expect_push    = owed;
		expect_value   = RESULT_WIDTH'(want);
		stop_data_load = stop;
		next_cycle();
		load_data      = 1'b0;
		expect_push    = 1'b0;
		stop_data_load = 1'b0;
	endtask

	// Owed results arrive within the fixed latency, then the checker audits the queue
	task automatic drain_group();
		repeat (LATENCY) next_cycle();
		end_check = 1'b1;
		next_cycle();
		end_check = 1'b0;
	endtask

	initial begin
		rst_n             = 1'b0;
		load_coefficients = 1'b0;
		coefficient_in    = '0;
		load_data         = 1'b0;
		data_in           = '0;
		stop_data_load    = 1'b0;
		expect_push       = 1'b0;
		expect_value      = '0;
		state_check       = 1'b0;
		state_expect      = fir_pkg::st_idle;
		end_check         = 1'b0;
		test_name         = "startup";
		fd = $fopen(PATTERN_FILE, "r");
		if (fd == 0) begin
			$display("Pattern file %0s could not be opened", PATTERN_FILE);
			file_errors++;
		end else begin
			// The first pass only sizes the watchdog
			while ($fgets(line, fd) > 0)
				line_count++;
			$fclose(fd);
			fd = $fopen(PATTERN_FILE, "r");
		end
		counted = 1'b1;
		while (fd != 0 && $fgets(line, fd) > 0) begin
			kind   = '0;
			fields = $sscanf(line, "%s %d %d", kind, value, result);
			if (kind == "test") begin
				if (started)
					drain_group();
				started = 1'b1;
				fields  = $sscanf(line, "%s %s %d", kind, test_name, value);
				gapped  = (value != 0);
				apply_reset();
			end else if (kind == "coeff") begin
				load_coefficient(value);
			end else if (kind == "sample" || kind == "stop") begin
				if (gapped)
					repeat ({next_random_bit(), next_random_bit(), next_random_bit()})
						next_cycle();
				strobe(value, 1'b1, result, kind == "stop");
				if (kind == "stop")
					expect_state(fir_pkg::st_stopped);
			end else if (kind == "stray") begin
				strobe(value, 1'b0, 0, 1'b0);
			end else if (fields > 0 && kind != "#") begin
				$display("Unknown record kind %0s in the pattern file", kind);
				file_errors++;
			end
		end
		if (started) begin
			drain_group();
		end else begin
			$display("The pattern file holds no test group");
			file_errors++;
		end
		$display("Errors: %0d from the checker, %0d from the pattern file",
			checker_errors, file_errors);
		if (checker_errors == 0 && file_errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

	// Each pattern line needs at most a gap, a strobe and a little overhead
	initial begin
		wait (counted);
		repeat (line_count * 9 + 200) @(posedge clock);
		$display("Watchdog timeout, the run did not end within %0d cycles", line_count * 9 + 200);
		$display("Something failed");
		$finish;
	end

endmodule
